// File: design/ipd_cfg.svh
// Configuration macros: queue count, stream widths, delay field, register map and control bits
`ifndef IPD_CFG_SVH
`define IPD_CFG_SVH

`define IPD_NUM_QUEUES 4

`define IPD_DATA_W  64
`define IPD_TUSER_W 32
`define IPD_TS_POS  0
`define IPD_TS_W    16

`define IPD_REG_W  32
`define IPD_ADDR_W 4

`define IPD_CTRL_SW_RST  0
`define IPD_CTRL_EN      1
`define IPD_CTRL_USE_REG 2

`endif

// File: design/ipd_pkg.sv
// Package with the stream beat, queue control and register bus struct types
`include "ipd_cfg.svh"

package ipd_pkg;

  // One stream beat, tstrb is not carried
  typedef struct packed {
    logic [`IPD_DATA_W-1:0]  data;
    logic [`IPD_TUSER_W-1:0] tuser;
    logic                    last;
  } axis_beat_t;

  // Per-queue control, decoded from the register pair
  typedef struct packed {
    logic                  sw_rst;
    logic                  en;
    logic                  use_reg;
    logic [`IPD_REG_W-1:0] delay;
  } queue_ctrl_t;

  // Simple register access strobes
  typedef struct packed {
    logic                   wr;
    logic                   rd;
    logic [`IPD_ADDR_W-1:0] addr;
    logic [`IPD_REG_W-1:0]  wdata;
  } reg_bus_t;

endpackage

// File: design/ipd_ctrl.sv
// Register file with per-queue control and delay registers, read-back and control unpacking
`timescale 1ns/1ns
`include "ipd_cfg.svh"

module ipd_ctrl (
  input  logic                    axi_aclk,
  input  logic                    reset,
  input  ipd_pkg::reg_bus_t       reg_bus,
  output logic [`IPD_REG_W-1:0]   rdata,
  output logic                    rvalid,
  output ipd_pkg::queue_ctrl_t    ctrl [`IPD_NUM_QUEUES]
);

  // Two registers per queue: control at 2q, delay at 2q+1
  localparam int NUM_REGS = 2 * `IPD_NUM_QUEUES;
  localparam int IDX_W    = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

  logic [`IPD_REG_W-1:0] regs [NUM_REGS];
  logic [IDX_W-1:0]      idx;
  logic                  in_map;

  // Address decode shared by writes and reads
  assign idx    = reg_bus.addr[IDX_W-1:0];
  assign in_map = (int'(reg_bus.addr) < NUM_REGS);

  // Writes land on the edge where wr is high
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (reg_bus.wr && in_map) begin
      regs[idx] <= reg_bus.wdata;
    end
  end

  // Read data, addresses past the map give zero
  always_ff @(posedge axi_aclk) begin
    if (reg_bus.rd) begin
      if (in_map) begin
        rdata <= regs[idx];
      end else begin
        rdata <= '0;
      end
    end
  end

  // One-cycle pulse, one edge after rd
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= reg_bus.rd;
    end
  end

  // Unpack each register pair into the queue's control struct
  genvar q;
  generate
    for (q = 0; q < `IPD_NUM_QUEUES; q++) begin : g_unpack
      assign ctrl[q].sw_rst  = regs[2*q][`IPD_CTRL_SW_RST];
      assign ctrl[q].en      = regs[2*q][`IPD_CTRL_EN];
      assign ctrl[q].use_reg = regs[2*q][`IPD_CTRL_USE_REG];
      assign ctrl[q].delay   = regs[2*q+1];
    end
  endgenerate

endmodule

// File: design/ipd_gap_timer.sv
// Gap timer: loadable down-counter that keeps a queue idle for a set number of cycles
`timescale 1ns/1ns
`include "ipd_cfg.svh"

module ipd_gap_timer (
  input  logic                  axi_aclk,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  start,
  input  logic [`IPD_REG_W-1:0] load_count,
  output logic                  busy
);

  // Remaining idle cycles
  logic [`IPD_REG_W-1:0] count;

  // Clear wins over start, start wins over the count-down.
  // Loading zero leaves the timer idle, so a zero delay adds no gap
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (start) begin
      count <= load_count;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Busy for exactly load_count cycles after the start edge
  assign busy = (count != '0);

endmodule

// File: design/ipd_queue.sv
// Queue datapath: pass-through stream gated by the gap timer, with delay source select
`timescale 1ns/1ns
`include "ipd_cfg.svh"

module ipd_queue (
  input  logic                 axi_aclk,
  input  logic                 reset,
  input  ipd_pkg::queue_ctrl_t ctrl,
  input  ipd_pkg::axis_beat_t  in_beat,
  input  logic                 in_valid,
  output logic                 in_ready,
  output ipd_pkg::axis_beat_t  out_beat,
  output logic                 out_valid,
  input  logic                 out_ready
);

  logic                  busy;
  logic                  last_xfer;
  logic [`IPD_TS_W-1:0]  ts_delay;
  logic [`IPD_REG_W-1:0] gap_len;

  // Zero-latency path, the beat itself is never held
  assign out_beat = in_beat;

  // Handshake closed in both directions during a gap
  assign out_valid = in_valid & ~busy;
  assign in_ready  = out_ready & ~busy;

  // Last beat accepted on an enabled queue starts a gap
  assign last_xfer = in_valid & in_ready & in_beat.last & ctrl.en;

  // Delay field of the last beat, widened to register size
  assign ts_delay = in_beat.tuser[`IPD_TS_POS +: `IPD_TS_W];

  always_comb begin
    if (ctrl.use_reg) begin
      gap_len = ctrl.delay;
    end else begin
      gap_len = {{(`IPD_REG_W - `IPD_TS_W){1'b0}}, ts_delay};
    end
  end

  // sw_rst ends any running gap and holds the timer idle
  ipd_gap_timer u_gap_timer (
    .axi_aclk   (axi_aclk),
    .reset      (reset),
    .clear      (ctrl.sw_rst),
    .start      (last_xfer),
    .load_count (gap_len),
    .busy       (busy)
  );

endmodule

// File: design/ipd_top.sv
// Top level with the register block and one gap-controlled datapath per queue
`timescale 1ns/1ns
`include "ipd_cfg.svh"

module ipd_top (
  input  logic                  axi_aclk,
  input  logic                  reset,

  // Register port
  input  ipd_pkg::reg_bus_t     reg_bus,
  output logic [`IPD_REG_W-1:0] rdata,
  output logic                  rvalid,

  // Input streams
  input  ipd_pkg::axis_beat_t   in_beat   [`IPD_NUM_QUEUES],
  input  logic                  in_valid  [`IPD_NUM_QUEUES],
  output logic                  in_ready  [`IPD_NUM_QUEUES],

  // Output streams
  output ipd_pkg::axis_beat_t   out_beat  [`IPD_NUM_QUEUES],
  output logic                  out_valid [`IPD_NUM_QUEUES],
  input  logic                  out_ready [`IPD_NUM_QUEUES]
);
  import ipd_pkg::*;

  queue_ctrl_t ctrl [`IPD_NUM_QUEUES];

  ipd_ctrl u_ctrl (
    .axi_aclk (axi_aclk),
    .reset    (reset),
    .reg_bus  (reg_bus),
    .rdata    (rdata),
    .rvalid   (rvalid),
    .ctrl     (ctrl)
  );

  // One datapath per queue with its own control struct
  genvar q;
  generate
    for (q = 0; q < `IPD_NUM_QUEUES; q++) begin : g_queue
      ipd_queue u_queue (
        .axi_aclk  (axi_aclk),
        .reset     (reset),
        .ctrl      (ctrl[q]),
        .in_beat   (in_beat[q]),
        .in_valid  (in_valid[q]),
        .in_ready  (in_ready[q]),
        .out_beat  (out_beat[q]),
        .out_valid (out_valid[q]),
        .out_ready (out_ready[q])
      );
    end
  endgenerate

endmodule

// File: test/ipd_tb.sv
// Testbench for the inter-packet delay block: file-driven register, gap and stream checks
`timescale 1ns/1ns
`include "ipd_cfg.svh"

module ipd_tb;
  import ipd_pkg::*;

  localparam int NQ      = `IPD_NUM_QUEUES;
  localparam int MAX_OPS = 64;

  logic                  axi_aclk = 1'b0;
  logic                  reset;
  reg_bus_t              reg_bus;
  logic [`IPD_REG_W-1:0] rdata;
  logic                  rvalid;
  axis_beat_t            in_beat   [NQ];
  logic                  in_valid  [NQ];
  logic                  in_ready  [NQ];
  axis_beat_t            out_beat  [NQ];
  logic                  out_valid [NQ];
  logic                  out_ready [NQ];

  // Five words per command: opcode and four operands
  logic [31:0] prog [5*MAX_OPS];
  axis_beat_t  sent_q [NQ][$];
  logic [31:0] ctrl_shadow [NQ];

  integer seed;
  int     errors;
  int     checks;
  int     out_count;
  int     cycles = 0;
  int     limit = 200;
  int     num_ops;
  logic   stall_mode;

  ipd_top uut (
    .axi_aclk  (axi_aclk),
    .reset     (reset),
    .reg_bus   (reg_bus),
    .rdata     (rdata),
    .rvalid    (rvalid),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #2 axi_aclk = ~axi_aclk;

  always @(posedge axi_aclk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  // Sink side, roughly one stall in four while stalling
  always @(posedge axi_aclk) begin
    logic [31:0] rnd;
    #1;
    for (int q = 0; q < NQ; q++) begin
      rnd = $random(seed);
      out_ready[q] = stall_mode ? (rnd[1:0] != 2'b00) : 1'b1;
    end
  end

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  // Output transfers happen at the next rising edge
  always @(negedge axi_aclk) begin
    if (!reset) begin
      for (int q = 0; q < NQ; q++) begin
        if (out_valid[q] && out_ready[q]) begin
          out_count++;
          if (sent_q[q].size() == 0) begin
            errors++;
            $display("Queue %0d put out a beat that was never sent, at %0t ns", q, $time);
          end else begin
            check(128'(out_beat[q]), 128'(sent_q[q].pop_front()),
                  $sformatf("output beat on queue %0d", q));
          end
        end
      end
    end
  end

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    int idx;
    idx = int'(addr);
    reg_bus.wr    = 1'b1;
    reg_bus.addr  = addr[`IPD_ADDR_W-1:0];
    reg_bus.wdata = data;
    if (idx < 2 * NQ && addr[0] == 1'b0) begin
      ctrl_shadow[idx / 2] = data;
    end
    @(posedge axi_aclk);
    #1;
    reg_bus.wr = 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp);
    reg_bus.rd   = 1'b1;
    reg_bus.addr = addr[`IPD_ADDR_W-1:0];
    @(negedge axi_aclk);
    check(128'(rvalid), 128'(1'b0), "rvalid before the read edge");
    @(posedge axi_aclk);
    #1;
    reg_bus.rd = 1'b0;
    @(negedge axi_aclk);
    check(128'(rvalid), 128'(1'b1), "rvalid one cycle after rd");
    check(128'(rdata), 128'(exp), $sformatf("read data at address %0h", addr));
    @(negedge axi_aclk);
    check(128'(rvalid), 128'(1'b0), "rvalid pulse width");
    @(posedge axi_aclk);
    #1;
  endtask

  task automatic send_packet(input int q, input int len, input logic [31:0] tdelay);
    axis_beat_t beat;
    for (int i = 0; i < len; i++) begin
      beat.data  = {$random(seed), $random(seed)};
      beat.tuser = $random(seed);
      beat.tuser[`IPD_TS_POS +: `IPD_TS_W] = tdelay[`IPD_TS_W-1:0];
      beat.last  = (i == len - 1);
      sent_q[q].push_back(beat);
      in_beat[q]  = beat;
      in_valid[q] = 1'b1;
      do begin
        @(negedge axi_aclk);
      end while (!in_ready[q]);
      @(posedge axi_aclk);
      #1;
    end
    in_valid[q] = 1'b0;
  endtask

  // Idle cycles seen on in_ready, with out_ready held high
  task automatic measure_gap(input int q, output int gap);
    gap = 0;
    @(negedge axi_aclk);
    while (!in_ready[q]) begin
      gap++;
      @(negedge axi_aclk);
    end
    @(posedge axi_aclk);
    #1;
  endtask

  task automatic packet_gap(input int q, input int len, input logic [31:0] tdelay,
                            input int exp_gap);
    int gap;
    send_packet(q, len, tdelay);
    measure_gap(q, gap);
    check(128'(gap), 128'(exp_gap), $sformatf("gap after packet on queue %0d", q));
  endtask

  task automatic send_packets(input int q, input int pkts, input int len,
                              input logic [31:0] tdelay);
    repeat (pkts) begin
      send_packet(q, len, tdelay);
    end
  endtask

  task automatic run_stress(input int pkts, input int len, input logic [31:0] tdelay,
                            input int exp_beats);
    out_count  = 0;
    stall_mode = 1'b1;
    for (int q = 0; q < NQ; q++) begin
      automatic int qq = q;
      fork
        send_packets(qq, pkts, len, tdelay);
      join_none
    end
    wait fork;
    stall_mode = 1'b0;
    check(128'(out_count), 128'(exp_beats), "beats out under back-pressure");
    for (int q = 0; q < NQ; q++) begin
      check(128'(sent_q[q].size()), 128'(0), $sformatf("beats left on queue %0d", q));
    end
  endtask

  // sw_rst raised part way into a gap, then dropped again
  task automatic cut_gap(input int q, input int len, input int wait_cycles, input int exp_gap);
    int          gap;
    logic [31:0] ctrl_val;
    ctrl_val = ctrl_shadow[q];
    send_packet(q, len, 0);
    fork
      measure_gap(q, gap);
      begin
        repeat (wait_cycles) begin
          @(posedge axi_aclk);
          #1;
        end
        write_reg(32'(2 * q), ctrl_val | (32'd1 << `IPD_CTRL_SW_RST));
      end
    join
    write_reg(32'(2 * q), ctrl_val);
    check(128'(gap), 128'(exp_gap), $sformatf("gap cut by sw_rst on queue %0d", q));
  endtask

  task automatic run_op(input logic [31:0] op, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] c, input logic [31:0] d);
    case (op)
      32'h1: write_reg(a, b);
      32'h2: read_reg(a, b);
      32'h3: packet_gap(int'(a), int'(b), c, int'(d));
      32'h4: run_stress(int'(a), int'(b), c, int'(d));
      32'h5: cut_gap(int'(a), int'(b), int'(c), int'(d));
      default: begin
        errors++;
        $display("Unknown opcode %0h in the input file", op);
      end
    endcase
  endtask

  initial begin
    seed       = 66;
    errors     = 0;
    checks     = 0;
    out_count  = 0;
    stall_mode = 1'b0;
    reset      = 1'b1;
    reg_bus    = '0;
    for (int q = 0; q < NQ; q++) begin
      in_beat[q]     = '0;
      in_valid[q]    = 1'b0;
      out_ready[q]   = 1'b1;
      ctrl_shadow[q] = '0;
    end
    for (int i = 0; i < 5 * MAX_OPS; i++) begin
      prog[i] = '0;
    end
    $readmemh("test/ipd_input.txt", prog);
    num_ops = 0;
    while (num_ops < MAX_OPS && prog[5*num_ops] != 32'h0) begin
      num_ops++;
    end
    limit = 40 * num_ops + 200;

    repeat (10) @(posedge axi_aclk);
    #1;
    reset = 1'b0;
    @(negedge axi_aclk);
    for (int q = 0; q < NQ; q++) begin
      check(128'(out_valid[q]), 128'(1'b0), $sformatf("out_valid after reset, queue %0d", q));
    end
    @(posedge axi_aclk);
    #1;

    for (int i = 0; i < num_ops; i++) begin
      run_op(prog[5*i], prog[5*i+1], prog[5*i+2], prog[5*i+3], prog[5*i+4]);
    end

    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+design
design/ipd_pkg.sv
design/ipd_ctrl.sv
design/ipd_gap_timer.sv
design/ipd_queue.sv
design/ipd_top.sv
test/ipd_tb.sv

// File: Makefile
# Verilator build and run of the inter-packet delay testbench

VERILATOR ?= verilator
TOP       ?= ipd_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/ipd_input.txt
// op a b c d in hex: 1 write addr data, 2 read addr expect, 3 packet q len tdelay gap,
// 4 stress pkts len tdelay beats, 5 sw_rst q len wait gap
2 0 0 0 0
2 1 0 0 0
2 2 0 0 0
2 3 0 0 0
2 4 0 0 0
2 5 0 0 0
2 6 0 0 0
2 7 0 0 0
1 0 6 0 0        // q0 enabled, delay from register
1 1 5 0 0
2 0 6 0 0
2 1 5 0 0
1 9 abc 0 0      // past the map, dropped
2 9 0 0 0
2 1 5 0 0
3 0 3 7 5
1 1 c 0 0
3 0 1 0 c
1 1 0 0 0
3 0 2 3 0
1 2 2 0 0        // q1 enabled, delay from tuser
3 1 4 9 9
3 1 2 0 0
3 2 3 8 0        // q2 still disabled
1 4 2 0 0
1 6 6 0 0
1 7 28 0 0
5 3 2 3 5        // sw_rst three cycles into a 40 cycle gap
4 3 4 2 30
